//--- rtl/alu_pkg.sv
/*
  widths, opcode and condition enums, flag word layout
*/
`default_nettype none

package alu_pkg;

  localparam int DATA_W  = 64;
  localparam int HALF_W  = 32;
  localparam int FLAGS_W = 6;

  typedef enum logic [4:0] {
    OP_ADD64,
    OP_ADD32,
    OP_SUB64,
    OP_SUB32,
    OP_AND64,
    OP_AND32,
    OP_OR64,
    OP_OR32,
    OP_XOR64,
    OP_XOR32,
    OP_XNOR64,
    OP_XNOR32,
    OP_MOV64,
    OP_MOV32,
    OP_ZXT8,
    OP_ZXT16,
    OP_SXT8,
    OP_SXT16,
    OP_SXT32,
    OP_CMOV,
    OP_CSET
  } alu_op_e;

  // same order as the jump condition field
  typedef enum logic [3:0] {
    C_Z, C_NZ, C_S, C_NS,
    C_UGT, C_ULE, C_UGE, C_ULT,
    C_SGT, C_SLE, C_SGE, C_SLT,
    C_O, C_NO, C_P, C_ALWAYS
  } cond_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a; // nibble carry
    logic s;
    logic z;
    logic p; // never set
  } flags_t;

endpackage

`default_nettype wire

//--- rtl/add_status_if.sv
/*
  adder sum and carry/overflow status
*/
`default_nettype none

interface add_status_if;
  import alu_pkg::*;

  logic [DATA_W-1:0] sum;
  logic carry_nib; // inverted for subtract
  logic carry32;
  logic carry64;
  logic ovf32;
  logic ovf64;

  modport adder (output sum, carry_nib, carry32, carry64, ovf32, ovf64);
  modport wb (input sum, carry_nib, carry32, carry64, ovf32, ovf64);

endinterface

`default_nettype wire

//--- rtl/cond_eval.sv
/*
  condition code evaluation over the flag word
*/
`default_nettype none

module cond_eval (
  input  wire alu_pkg::flags_t flags,
  input  wire alu_pkg::cond_e  cond,
  output logic                 taken
);
  import alu_pkg::*;

  logic lt; // signed less-than

  assign lt = flags.s ^ flags.o;

  always_comb begin
    taken = 1'b0;
    case (cond)
      C_Z:      taken = flags.z;
      C_NZ:     taken = ~flags.z;
      C_S:      taken = flags.s;
      C_NS:     taken = ~flags.s;
      C_UGT:    taken = flags.c & ~flags.z; // carry means no borrow
      C_ULE:    taken = ~flags.c | flags.z;
      C_UGE:    taken = flags.c;
      C_ULT:    taken = ~flags.c;
      C_SGT:    taken = ~(lt | flags.z);
      C_SLE:    taken = lt | flags.z;
      C_SGE:    taken = ~lt;
      C_SLT:    taken = lt;
      C_O:      taken = flags.o;
      C_NO:     taken = ~flags.o;
      C_P:      taken = flags.p;
      C_ALWAYS: taken = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/alu_adder.sv
/*
  64-bit add/subtract with nibble, 32-bit and 64-bit carry and overflow
*/
`default_nettype none

module alu_adder (
  input  wire [alu_pkg::DATA_W-1:0] a,
  input  wire [alu_pkg::DATA_W-1:0] b,
  input  wire alu_pkg::alu_op_e     op,
  add_status_if.adder               st
);
  import alu_pkg::*;

  logic              sub;
  logic [DATA_W-1:0] b_eff;
  logic [DATA_W:0]   full;

  assign sub   = (op == OP_SUB64) || (op == OP_SUB32);
  assign b_eff = sub ? ~b : b;

  // a - b as a + ~b + 1
  assign full = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, sub};

  assign st.sum = full[DATA_W-1:0];

  // carry into bit i recovered as sum ^ a ^ b at bit i
  assign st.carry_nib = (full[4] ^ a[4] ^ b_eff[4]) ^ sub;
  assign st.carry32   = full[HALF_W] ^ a[HALF_W] ^ b_eff[HALF_W];
  assign st.carry64   = full[DATA_W];

  // operands of like sign giving a result of the other sign
  assign st.ovf32 = (a[HALF_W-1] == b_eff[HALF_W-1]) &&
                    (full[HALF_W-1] != a[HALF_W-1]);
  assign st.ovf64 = (a[DATA_W-1] == b_eff[DATA_W-1]) &&
                    (full[DATA_W-1] != a[DATA_W-1]);

endmodule

`default_nettype wire

//--- rtl/alu_logic_mov.sv
/*
  logic ops, moves, zero/sign extension, cmov and cset
*/
`default_nettype none

module alu_logic_mov (
  input  wire [alu_pkg::DATA_W-1:0] a,
  input  wire [alu_pkg::DATA_W-1:0] b,
  input  wire alu_pkg::alu_op_e     op,
  input  wire alu_pkg::cond_e       cond,
  input  wire alu_pkg::flags_t      flags_in,
  output logic [alu_pkg::DATA_W-1:0] logic_res
);
  import alu_pkg::*;

  logic              taken;
  logic [DATA_W-1:0] and_v;
  logic [DATA_W-1:0] or_v;
  logic [DATA_W-1:0] xor_v;
  logic [DATA_W-1:0] xnor_v;

  cond_eval i_cond (
    .flags (flags_in),
    .cond  (cond),
    .taken (taken)
  );

  assign and_v  = a & b;
  assign or_v   = a | b;
  assign xor_v  = a ^ b;
  assign xnor_v = ~xor_v;

  always_comb begin
    logic_res = '0;
    case (op)
      OP_AND64:  logic_res = and_v;
      OP_AND32:  logic_res = {{HALF_W{1'b0}}, and_v[HALF_W-1:0]};
      OP_OR64:   logic_res = or_v;
      OP_OR32:   logic_res = {{HALF_W{1'b0}}, or_v[HALF_W-1:0]};
      OP_XOR64:  logic_res = xor_v;
      OP_XOR32:  logic_res = {{HALF_W{1'b0}}, xor_v[HALF_W-1:0]};
      OP_XNOR64: logic_res = xnor_v;
      OP_XNOR32: logic_res = {{HALF_W{1'b0}}, xnor_v[HALF_W-1:0]};
      OP_MOV64:  logic_res = b;
      OP_MOV32:  logic_res = {{HALF_W{1'b0}}, b[HALF_W-1:0]};
      OP_ZXT8:   logic_res = {{(DATA_W-8){1'b0}}, b[7:0]};
      OP_ZXT16:  logic_res = {{(DATA_W-16){1'b0}}, b[15:0]};
      OP_SXT8:   logic_res = {{(DATA_W-8){b[7]}}, b[7:0]};
      OP_SXT16:  logic_res = {{(DATA_W-16){b[15]}}, b[15:0]};
      OP_SXT32:  logic_res = {{HALF_W{b[HALF_W-1]}}, b[HALF_W-1:0]};
      OP_CMOV:   logic_res = taken ? b : a;
      OP_CSET:   logic_res = {{(DATA_W-1){1'b0}}, taken};
      default:   logic_res = '0; // add/sub handled by the adder
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/alu_writeback.sv
/*
  result select, flag computation, output registers
*/
`default_nettype none

module alu_writeback (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        op_valid,
  input  wire alu_pkg::alu_op_e      op,
  input  wire                        set_flags,
  add_status_if.wb                   st,
  input  wire [alu_pkg::DATA_W-1:0]  logic_res,
  output logic                       res_valid,
  output logic [alu_pkg::DATA_W-1:0] result,
  output alu_pkg::flags_t            flags_out,
  output logic                       flags_we
);
  import alu_pkg::*;

  logic              is_arith;
  logic              is_logic;
  logic [DATA_W-1:0] sel_res;
  flags_t            sel_flags;

  always_comb begin
    is_arith  = 1'b0;
    is_logic  = 1'b0;
    sel_res   = logic_res;
    sel_flags = '0; // p stays clear
    case (op)
      OP_ADD64, OP_SUB64: begin
        is_arith    = 1'b1;
        sel_res     = st.sum;
        sel_flags.c = st.carry64;
        sel_flags.o = st.ovf64;
        sel_flags.a = st.carry_nib;
        sel_flags.s = st.sum[DATA_W-1];
        sel_flags.z = (st.sum == '0);
      end
      OP_ADD32, OP_SUB32: begin
        is_arith    = 1'b1;
        sel_res     = {{HALF_W{1'b0}}, st.sum[HALF_W-1:0]};
        sel_flags.c = st.carry32;
        sel_flags.o = st.ovf32;
        sel_flags.a = st.carry_nib;
        sel_flags.s = st.sum[HALF_W-1];
        sel_flags.z = (st.sum[HALF_W-1:0] == '0);
      end
      OP_AND64, OP_OR64, OP_XOR64, OP_XNOR64: begin
        is_logic    = 1'b1;
        sel_flags.s = logic_res[DATA_W-1];
        sel_flags.z = (logic_res == '0);
      end
      OP_AND32, OP_OR32, OP_XOR32, OP_XNOR32: begin
        is_logic    = 1'b1;
        sel_flags.s = logic_res[HALF_W-1];
        sel_flags.z = (logic_res[HALF_W-1:0] == '0);
      end
      default: ; // moves, extensions, cmov, cset leave flags clear
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      flags_we  <= 1'b0;
      result    <= '0;
      flags_out <= '0;
    end else begin
      res_valid <= op_valid;
      flags_we  <= op_valid && set_flags && (is_arith || is_logic);
      if (op_valid) begin
        result    <= sel_res;
        flags_out <= sel_flags;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_top.sv
/*
  single-stage integer ALU top level
*/
`default_nettype none

module alu_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        op_valid,
  input  wire alu_pkg::alu_op_e      op,
  input  wire                        set_flags,
  input  wire alu_pkg::cond_e        cond,
  input  wire [alu_pkg::DATA_W-1:0]  a,
  input  wire [alu_pkg::DATA_W-1:0]  b,
  input  wire alu_pkg::flags_t       flags_in,
  output logic                       res_valid,
  output logic [alu_pkg::DATA_W-1:0] result,
  output alu_pkg::flags_t            flags_out,
  output logic                       flags_we
);
  import alu_pkg::*;

  logic [DATA_W-1:0] logic_res;

  add_status_if add_st ();

  alu_adder i_adder (
    .a  (a),
    .b  (b),
    .op (op),
    .st (add_st.adder)
  );

  alu_logic_mov i_logic (
    .a         (a),
    .b         (b),
    .op        (op),
    .cond      (cond),
    .flags_in  (flags_in),
    .logic_res (logic_res)
  );

  alu_writeback i_wb (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op        (op),
    .set_flags (set_flags),
    .st        (add_st.wb),
    .logic_res (logic_res),
    .res_valid (res_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

endmodule

`default_nettype wire

//--- include/alu_ref_model.svh
/*
  reference model for the condition, result and flags of one ALU operation
*/
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

function automatic logic ref_cond(alu_pkg::flags_t f, alu_pkg::cond_e c);
  logic [15:0] tbl; // indexed by condition code
  tbl = {1'b1, f.p, ~f.o, f.o,
         (f.s ^ f.o), ~(f.s ^ f.o), (f.s ^ f.o) | f.z, ~((f.s ^ f.o) | f.z),
         ~f.c, f.c, ~f.c | f.z, f.c & ~f.z,
         ~f.s, f.s, ~f.z, f.z};
  return tbl[c];
endfunction

function automatic logic [63:0] ref_result(alu_pkg::alu_op_e op, alu_pkg::cond_e c,
                                           logic [63:0] a, logic [63:0] b,
                                           alu_pkg::flags_t f);
  logic [63:0] r;
  case (op)
    alu_pkg::OP_ADD64:  r = a + b;
    alu_pkg::OP_SUB64:  r = a - b;
    alu_pkg::OP_ADD32:  r = {32'b0, a[31:0] + b[31:0]};
    alu_pkg::OP_SUB32:  r = {32'b0, a[31:0] - b[31:0]};
    alu_pkg::OP_AND64:  r = a & b;
    alu_pkg::OP_OR64:   r = a | b;
    alu_pkg::OP_XOR64:  r = a ^ b;
    alu_pkg::OP_XNOR64: r = a ~^ b;
    alu_pkg::OP_AND32:  r = {32'b0, a[31:0] & b[31:0]};
    alu_pkg::OP_OR32:   r = {32'b0, a[31:0] | b[31:0]};
    alu_pkg::OP_XOR32:  r = {32'b0, a[31:0] ^ b[31:0]};
    alu_pkg::OP_XNOR32: r = {32'b0, a[31:0] ~^ b[31:0]};
    alu_pkg::OP_MOV64:  r = b;
    alu_pkg::OP_MOV32:  r = {32'b0, b[31:0]};
    alu_pkg::OP_ZXT8:   r = {56'b0, b[7:0]};
    alu_pkg::OP_ZXT16:  r = {48'b0, b[15:0]};
    alu_pkg::OP_SXT8:   r = 64'($signed(b[7:0]));
    alu_pkg::OP_SXT16:  r = 64'($signed(b[15:0]));
    alu_pkg::OP_SXT32:  r = 64'($signed(b[31:0]));
    alu_pkg::OP_CMOV:   r = ref_cond(f, c) ? b : a;
    alu_pkg::OP_CSET:   r = {63'b0, ref_cond(f, c)};
    default:            r = '0;
  endcase
  return r;
endfunction

function automatic alu_pkg::flags_t ref_flags(alu_pkg::alu_op_e op, logic [63:0] a,
                                              logic [63:0] b, logic [63:0] res);
  alu_pkg::flags_t f;
  logic sub;
  logic w32;
  logic [64:0] s64;
  logic [32:0] s32;
  f   = '0;
  sub = (op == alu_pkg::OP_SUB64) || (op == alu_pkg::OP_SUB32);
  w32 = (op == alu_pkg::OP_ADD32) || (op == alu_pkg::OP_SUB32);
  s64 = {1'b0, a} + {1'b0, b};
  s32 = {1'b0, a[31:0]} + {1'b0, b[31:0]};
  case (op)
    alu_pkg::OP_ADD64, alu_pkg::OP_SUB64, alu_pkg::OP_ADD32, alu_pkg::OP_SUB32: begin
      // carry set means no borrow on subtract
      if (w32) f.c = sub ? (a[31:0] >= b[31:0]) : s32[32];
      else f.c = sub ? (a >= b) : s64[64];
      f.a = sub ? (a[3:0] < b[3:0]) : ({1'b0, a[3:0]} + {1'b0, b[3:0]} > 5'd15);
      if (w32) f.o = ((a[31] ^ b[31]) == sub) && (res[31] != a[31]);
      else f.o = ((a[63] ^ b[63]) == sub) && (res[63] != a[63]);
      f.s = w32 ? res[31] : res[63];
      f.z = w32 ? (res[31:0] == 0) : (res == 0);
    end
    alu_pkg::OP_AND64, alu_pkg::OP_OR64, alu_pkg::OP_XOR64, alu_pkg::OP_XNOR64: begin
      f.s = res[63];
      f.z = (res == 0);
    end
    alu_pkg::OP_AND32, alu_pkg::OP_OR32, alu_pkg::OP_XOR32, alu_pkg::OP_XNOR32: begin
      f.s = res[31];
      f.z = (res[31:0] == 0);
    end
    default: ;
  endcase
  return f;
endfunction

`endif

//--- test/tb_alu.sv
/*
  testbench for alu_top with directed, condition and random ops checked by assertions
*/
`default_nettype none

module tb_alu;
  import alu_pkg::*;

  `include "alu_ref_model.svh"

  localparam int N_RAND  = 400;
  localparam int MAX_OPS = N_RAND + 300; // directed and cond ops fit in the extra 300

  logic clk = 1'b0;
  logic rst, op_valid, set_flags;
  alu_op_e op;
  cond_e cond;
  logic [63:0] a, b;
  flags_t flags_in;
  logic res_valid, flags_we;
  logic [63:0] result;
  flags_t flags_out;

  logic exp_valid, exp_we;
  logic [63:0] exp_result;
  flags_t exp_flags;
  int n_ops = 0;
  int n_err = 0;
  integer seed = 38;

  alu_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .op        (op),
    .set_flags (set_flags),
    .cond      (cond),
    .a         (a),
    .b         (b),
    .flags_in  (flags_in),
    .res_valid (res_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

  always #4 clk = ~clk;

  function automatic logic flag_op(alu_op_e o);
    case (o)
      OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32, OP_AND64, OP_AND32, OP_OR64, OP_OR32,
      OP_XOR64, OP_XOR32, OP_XNOR64, OP_XNOR32: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // boundary values mixed into random operands
  function automatic logic [63:0] pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0:    return 64'h0;
      2'd1:    return {32'h0, $random(seed)}; // small values hit the 32-bit edges
      2'd2:    return {r[2], {63{~r[2]}}};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  task automatic issue(input alu_op_e o, input logic [63:0] x, input logic [63:0] y,
                       input logic sf, input cond_e c, input flags_t f);
    @(posedge clk);
    #1;
    op_valid = 1'b1;
    op = o;
    a = x;
    b = y;
    set_flags = sf;
    cond = c;
    flags_in = f;
    n_ops++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      op_valid = 1'b0;
    end
  endtask

  // one-deep expectation lined up with the DUT output register
  always @(posedge clk) begin
    if (rst) begin
      exp_valid <= 1'b0;
      exp_we    <= 1'b0;
    end else begin
      exp_valid <= op_valid;
      exp_we    <= op_valid && set_flags && flag_op(op);
      if (op_valid) begin
        exp_result <= ref_result(op, cond, a, b, flags_in);
        exp_flags  <= ref_flags(op, a, b, ref_result(op, cond, a, b, flags_in));
      end
    end
  end

  a_valid: assert property (@(negedge clk) disable iff (rst) res_valid == exp_valid)
    else begin
      n_err++;
      $display("[FAIL] %0t: res_valid %b, expected %b", $time, res_valid, exp_valid);
    end
  a_we: assert property (@(negedge clk) disable iff (rst) flags_we == exp_we)
    else begin
      n_err++;
      $display("[FAIL] %0t: flags_we %b, expected %b", $time, flags_we, exp_we);
    end
  a_result: assert property (@(negedge clk) disable iff (rst)
                             res_valid |-> result == exp_result)
    else begin
      n_err++;
      $display("[FAIL] %0t: result %h, expected %h", $time, result, exp_result);
    end
  a_flags: assert property (@(negedge clk) disable iff (rst)
                            res_valid |-> flags_out == exp_flags)
    else begin
      n_err++;
      $display("[FAIL] %0t: flags %b, expected %b", $time, flags_out, exp_flags);
    end

  initial begin
    #(MAX_OPS * 8 + 400);
    $display("timeout: the test sequence did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rst = 1'b1;
    op_valid = 1'b0;
    op = OP_ADD64;
    set_flags = 1'b0;
    cond = C_ALWAYS;
    a = '0;
    b = '0;
    flags_in = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);
    assert (result == '0 && flags_out == '0 && !res_valid && !flags_we) else begin
      n_err++;
      $display("[FAIL] %0t: outputs not cleared by reset", $time);
    end

    // max plus one, zero minus one, signed overflow at both widths
    issue(OP_ADD64, '1, 64'd1, 1'b1, C_ALWAYS, '0);
    idle(1);
    issue(OP_SUB64, 64'd0, 64'd1, 1'b1, C_ALWAYS, '0);
    issue(OP_ADD32, 64'hffff_ffff, 64'd1, 1'b0, C_ALWAYS, '0);
    issue(OP_SUB32, 64'd0, 64'd1, 1'b1, C_ALWAYS, '0);
    issue(OP_ADD64, 64'h7fff_ffff_ffff_ffff, 64'd1, 1'b1, C_ALWAYS, '0);
    issue(OP_SUB64, 64'h8000_0000_0000_0000, 64'd1, 1'b1, C_ALWAYS, '0);
    issue(OP_ADD32, 64'h7fff_ffff, 64'd1, 1'b1, C_ALWAYS, '0);
    issue(OP_SUB32, 64'h8000_0000, 64'd1, 1'b1, C_ALWAYS, '0);
    issue(OP_SUB64, 64'd5, 64'd5, 1'b1, C_ALWAYS, '0);
    idle(2);

    for (int i = int'(OP_AND64); i <= int'(OP_SXT32); i++)
      repeat (3) issue(alu_op_e'(i[4:0]), pick_operand(), pick_operand(), 1'b1, C_ALWAYS, '0);
    idle(2);

    for (int c = 0; c < 16; c++)
      repeat (3) begin
        r = $random(seed);
        issue(OP_CSET, pick_operand(), pick_operand(), r[8], cond_e'(c[3:0]), flags_t'(r[5:0]));
        issue(OP_CMOV, pick_operand(), pick_operand(), r[9], cond_e'(c[3:0]), flags_t'(r[5:0]));
      end

    // op from the low bits, set_flags from bit 31
    repeat (N_RAND) begin
      r = $random(seed);
      r = {r[31], 31'(r[30:0] % 31'd21)};
      issue(alu_op_e'(r[4:0]), pick_operand(), pick_operand(), r[31],
            cond_e'($random(seed)), flags_t'($random(seed)));
    end
    idle(4);

    $display("%0d operations, %0d errors", n_ops, n_err);
    if (n_err == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
rtl/alu_pkg.sv
rtl/add_status_if.sv
rtl/cond_eval.sv
rtl/alu_adder.sv
rtl/alu_logic_mov.sv
rtl/alu_writeback.sv
rtl/alu_top.sv
test/tb_alu.sv

//--- run.sh
#!/bin/sh
# build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module tb_alu -Mdir obj_dir -o sim_alu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_alu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
